//--- common/dot_pkg.sv
package dot_pkg;

  // word width for data, weights, products and sums
  parameter int DATA_W = 32;

  // lanes in one sample
  parameter int NUM_LANES = 16;

  // lanes folded into one partial sum
  parameter int LANES_PER_PE = 8;

  // number of partial sums
  parameter int NUM_PE = NUM_LANES / LANES_PER_PE;

  // q-format fraction position used when the top is not overridden
  parameter int DEF_FRAC_BITS = 15;

  // one signed fixed-point word
  typedef logic signed [DATA_W-1:0] word_t;

  // one input item, data lanes and their weights side by side
  // lane n sits at x[n] and w[n]
  typedef struct packed {
    word_t [NUM_LANES-1:0] x;
    word_t [NUM_LANES-1:0] w;
  } sample_t;

  // rescaled products, one per lane
  typedef word_t [NUM_LANES-1:0] product_vec_t;

  // partial sums, one per group of lanes
  // entry k covers lanes k*LANES_PER_PE up to k*LANES_PER_PE+LANES_PER_PE-1
  typedef word_t [NUM_PE-1:0] partial_vec_t;

endpackage

//--- pe8/lane_multiplier.sv
`timescale 1ns/100ps

module lane_multiplier import dot_pkg::*; #(
  // binary point position from 0 to DATA_W-1
  parameter int FRAC_BITS = DEF_FRAC_BITS
) (
  input  logic         clk,
  input  logic         i_rst_n,
  // upstream side
  input  logic         i_valid,
  input  sample_t      i_sample,
  output logic         o_ready,
  // downstream side
  output logic         o_valid,
  output product_vec_t o_products,
  input  logic         i_ready
);

  // full product is twice the word width so nothing is lost before the shift
  typedef logic signed [2*DATA_W-1:0] wide_t;

  // output register state
  logic         valid_q;
  product_vec_t products_q;

  // rescaled products for the sample now on the input
  product_vec_t products_d;

  // item taken from upstream this cycle
  logic         accept;

  // one multiplier per lane
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
    wide_t prod_full;
    wide_t prod_shift;

    // operands sign-extended to the full width before the multiply
    assign prod_full = wide_t'(i_sample.x[lane]) * wide_t'(i_sample.w[lane]);

    // arithmetic shift rounds toward minus infinity
    assign prod_shift = prod_full >>> FRAC_BITS;

    // upper bits drop off like any overflow
    assign products_d[lane] = prod_shift[DATA_W-1:0];
  end

  // room when empty or when the held item leaves this cycle
  assign o_ready = !valid_q || i_ready;
  assign accept  = i_valid && o_ready;

  // valid flag follows upstream whenever the register may be reloaded
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  // all sixteen lanes captured together
  always_ff @(posedge clk) begin
    if (accept) begin
      products_q <= products_d;
    end
  end

  assign o_valid    = valid_q;
  assign o_products = products_q;

endmodule

//--- pe8/partial_sum_tree.sv
`timescale 1ns/100ps

module partial_sum_tree import dot_pkg::*; (
  input  logic         clk,
  input  logic         i_rst_n,
  // upstream side
  input  logic         i_valid,
  input  product_vec_t i_products,
  output logic         o_ready,
  // downstream side
  output logic         o_valid,
  output partial_vec_t o_partials,
  input  logic         i_ready
);

  // nodes of one tree, heap order
  // node 0 is the root, leaves start at LANES_PER_PE-1
  localparam int NUM_NODES = 2 * LANES_PER_PE - 1;

  // output register state
  logic         valid_q;
  partial_vec_t partials_q;

  // tree results for the products now on the input
  partial_vec_t partials_d;

  // item taken from upstream this cycle
  logic         accept;

  // one adder tree per processing element
  for (genvar pe = 0; pe < NUM_PE; pe++) begin : g_pe
    word_t node [NUM_NODES];

    // leaves are this group's eight products
    for (genvar leaf = 0; leaf < LANES_PER_PE; leaf++) begin : g_leaf
      assign node[LANES_PER_PE-1+leaf] = i_products[pe*LANES_PER_PE+leaf];
    end

    // inner nodes add their two children
    // eight leaves give three adder levels, 4 then 2 then 1
    for (genvar n = 0; n < LANES_PER_PE - 1; n++) begin : g_add
      // word-width add, wraps on overflow
      assign node[n] = node[2*n+1] + node[2*n+2];
    end

    assign partials_d[pe] = node[0];
  end

  // same stage handshake as the multiplier
  assign o_ready = !valid_q || i_ready;
  assign accept  = i_valid && o_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  // both partial sums captured in one go
  always_ff @(posedge clk) begin
    if (accept) begin
      partials_q <= partials_d;
    end
  end

  assign o_valid    = valid_q;
  assign o_partials = partials_q;

endmodule

//--- hdl/result_combiner.sv
`timescale 1ns/100ps

module result_combiner import dot_pkg::*; (
  input  logic         clk,
  input  logic         i_rst_n,
  // upstream side
  input  logic         i_valid,
  input  partial_vec_t i_partials,
  output logic         o_ready,
  // external consumer side
  output logic         o_valid,
  output word_t        o_result,
  input  logic         i_ready
);

  // output register state
  logic  valid_q;
  word_t result_q;

  // sum of the incoming partials
  word_t result_d;

  // item taken from upstream this cycle
  logic  accept;

  // add every partial sum, modulo 2^DATA_W
  always_comb begin
    result_d = '0;
    for (int pe = 0; pe < NUM_PE; pe++) begin
      result_d = result_d + i_partials[pe];
    end
  end

  // held result stays put until the consumer takes it
  assign o_ready = !valid_q || i_ready;
  assign accept  = i_valid && o_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  // result word
  always_ff @(posedge clk) begin
    if (accept) begin
      result_q <= result_d;
    end
  end

  assign o_valid  = valid_q;
  assign o_result = result_q;

endmodule

//--- hdl/dot_layer_top.sv
`timescale 1ns/100ps

module dot_layer_top import dot_pkg::*; #(
  parameter int FRAC_BITS = DEF_FRAC_BITS
) (
  input  logic    clk,
  input  logic    i_rst_n,
  // sample stream in
  input  logic    i_valid,
  input  sample_t i_sample,
  output logic    o_ready,
  // result stream out
  output logic    o_valid,
  output word_t   o_result,
  input  logic    i_ready
);

  // multiplier to adder tree link
  logic         prod_valid;
  logic         prod_ready;
  product_vec_t products;

  // adder tree to combiner link
  logic         part_valid;
  logic         part_ready;
  partial_vec_t partials;

  // stage 1, lane products rescaled by the fraction position
  lane_multiplier #(
    .FRAC_BITS (FRAC_BITS)
  ) i_lane_multiplier (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_sample   (i_sample),
    .o_ready    (o_ready),
    .o_valid    (prod_valid),
    .o_products (products),
    .i_ready    (prod_ready)
  );

  // stage 2, one partial sum per group of eight lanes
  partial_sum_tree i_partial_sum_tree (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (prod_valid),
    .i_products (products),
    .o_ready    (prod_ready),
    .o_valid    (part_valid),
    .o_partials (partials),
    .i_ready    (part_ready)
  );

  // stage 3, final add and the external result port
  result_combiner i_result_combiner (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (part_valid),
    .i_partials (partials),
    .o_ready    (part_ready),
    .o_valid    (o_valid),
    .o_result   (o_result),
    .i_ready    (i_ready)
  );

endmodule

//--- tests/dot_layer_sva.sv
`timescale 1ns/100ps

module dot_layer_sva import dot_pkg::*; (
  input logic  clk,
  input logic  i_rst_n,
  input logic  o_valid,
  input word_t o_result,
  input logic  i_ready
);

  // stalled result keeps its valid and its value
  a_hold: assert property (
    @(posedge clk) disable iff (!i_rst_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_result))
  ) else $error("result stream changed while stalled");

  // valid always known out of reset
  a_known: assert property (
    @(posedge clk) disable iff (!i_rst_n) !$isunknown(o_valid)
  ) else $error("o_valid is unknown");

  // first edge out of reset has nothing to show
  a_idle: assert property (
    @(posedge clk) $rose(i_rst_n) |-> !o_valid
  ) else $error("o_valid high right after reset release");

endmodule

bind dot_layer_top dot_layer_sva i_dot_layer_sva (
  .clk      (clk),
  .i_rst_n  (i_rst_n),
  .o_valid  (o_valid),
  .o_result (o_result),
  .i_ready  (i_ready)
);

//--- tests/tb_dot_layer.sv
`timescale 1ns/100ps

module tb_dot_layer import dot_pkg::*; ();

  // fraction position of the DUT at its default
  localparam int FRAC = DEF_FRAC_BITS;
  // longest wait for any one event in clock cycles
  localparam int WAIT_LIMIT = 2000;

  logic    clk;
  logic    i_rst_n;
  logic    i_valid;
  sample_t i_sample;
  logic    o_ready;
  logic    o_valid;
  word_t   o_result;
  logic    i_ready;

  // xorshift state
  logic [31:0] rng_state;
  // expected results in acceptance order
  word_t   exp_q[$];
  // samples for the next stream run
  sample_t stim_q[$];
  // errors in the running test
  int      errs;
  int      tests_passed;
  int      tests_failed;
  bit      stalled;

  dot_layer_top i_dot_layer_top (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_sample (i_sample),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_result (o_result),
    .i_ready  (i_ready)
  );

  // 40 ns clock
  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic sample_t random_sample();
    sample_t s;
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = next_rand();
      s.w[l] = next_rand();
    end
    return s;
  endfunction

  // expected result from the q-format rule with wrapping group sums
  function automatic word_t model_result(sample_t s);
    logic signed [2*DATA_W-1:0] xe;
    logic signed [2*DATA_W-1:0] we;
    logic signed [2*DATA_W-1:0] prod;
    word_t part [NUM_PE];
    word_t total;
    for (int k = 0; k < NUM_PE; k++) begin
      part[k] = '0;
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      xe = {{DATA_W{s.x[l][DATA_W-1]}}, s.x[l]};
      we = {{DATA_W{s.w[l][DATA_W-1]}}, s.w[l]};
      prod = (xe * we) >>> FRAC;
      part[l / LANES_PER_PE] = part[l / LANES_PER_PE] + prod[DATA_W-1:0];
    end
    total = '0;
    for (int k = 0; k < NUM_PE; k++) begin
      total = total + part[k];
    end
    return total;
  endfunction

  task automatic check_value(input string tname, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %0d, actual %0d", tname, exp, act);
      errs++;
    end
  endtask

  task automatic check_flag(input string tname, input string sig, input bit exp,
                            input logic act);
    assert (act === exp) else begin
      $display("FAIL %s: %s expected %b, actual %b", tname, sig, exp, act);
      errs++;
    end
  endtask

  // one summary line per test
  task automatic end_test(input string tname);
    if (errs == 0) begin
      $display("%s: passed", tname);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", tname, errs);
      tests_failed++;
    end
    errs = 0;
  endtask

  // pushes stim_q through the DUT and compares every result in order
  // gaps puts random holes in i_valid and bp toggles i_ready
  task automatic run_stream(input string tname, input bit gaps, input bit bp,
                            output bit saw_stall);
    int n;
    int sent;
    int got;
    int cyc;
    bit hold;
    n = stim_q.size();
    sent = 0;
    got = 0;
    cyc = 0;
    hold = 1'b0;
    saw_stall = 1'b0;
    exp_q.delete();
    while (got < n && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      cyc++;
      if (sent < n) begin
        i_sample = stim_q[sent];
        // a stalled item stays valid until taken
        i_valid = hold || !gaps || ((next_rand() & 32'd3) != 32'd0);
      end else begin
        i_valid = 1'b0;
      end
      i_ready = bp ? ((next_rand() & 32'd7) < 32'd3) : 1'b1;
      // outputs and the ready chain settle well before the next rising edge
      #1;
      // with the consumer always ready the pipeline takes one sample per cycle
      if (!bp) begin
        assert (o_ready) else begin
          $display("%s: o_ready fell with i_ready held high", tname);
          errs++;
        end
      end
      // output side first so a result never matches the item taken this cycle
      if (o_valid && i_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: a result came out with none pending", tname);
          errs++;
        end
        if (exp_q.size() != 0) begin
          check_value(tname, exp_q.pop_front(), o_result);
        end
        got++;
      end
      if (i_valid && o_ready) begin
        exp_q.push_back(model_result(stim_q[sent]));
        sent++;
      end
      hold = i_valid && !o_ready;
      if (!i_ready && !o_ready) begin
        saw_stall = 1'b1;
      end
    end
    assert (got == n) else begin
      $display("%s: timed out with %0d of %0d results received", tname, got, n);
      errs++;
    end
    // nothing may follow the last result
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      i_valid = 1'b0;
      i_ready = 1'b1;
      #1;
      assert (!o_valid) else begin
        $display("%s: an extra result came out after the last one", tname);
        errs++;
      end
    end
  endtask

  task automatic reset_state();
    i_rst_n = 1'b0;
    // seven falling edges inside reset, release on the eighth
    for (int c = 0; c < 7; c++) begin
      @(negedge clk);
      #1;
      check_flag("reset_state", "o_valid", 1'b0, o_valid);
      check_flag("reset_state", "o_ready", 1'b1, o_ready);
    end
    @(negedge clk);
    i_rst_n = 1'b1;
    #1;
    check_flag("reset_state", "o_valid", 1'b0, o_valid);
    check_flag("reset_state", "o_ready", 1'b1, o_ready);
    @(negedge clk);
    #1;
    check_flag("reset_state", "o_valid", 1'b0, o_valid);
    check_flag("reset_state", "o_ready", 1'b1, o_ready);
    end_test("reset_state");
  endtask

  task automatic single_known();
    sample_t s;
    int      lat;
    // data 1 to 16 and every weight 1.0
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = l + 1;
      s.w[l] = 1 << FRAC;
    end
    @(negedge clk);
    i_sample = s;
    i_valid  = 1'b1;
    i_ready  = 1'b1;
    #1;
    assert (o_ready) else begin
      $display("single_known: the sample was not accepted");
      errs++;
    end
    // count falling edges until the result shows
    lat = 0;
    do begin
      @(negedge clk);
      i_valid = 1'b0;
      lat++;
      #1;
    end while (!o_valid && lat < WAIT_LIMIT);
    assert (o_valid) else begin
      $display("single_known: timed out waiting for o_valid");
      errs++;
    end
    // acceptance edge plus two more stages shows on the third falling edge
    check_value("single_known", 3, lat);
    check_value("single_known", 136, o_result);
    end_test("single_known");
  endtask

  task automatic signed_rescale();
    sample_t s;
    stim_q.delete();
    // -3 times 0.5 floors to -2 in every lane
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = -3;
      s.w[l] = 1 << (FRAC - 1);
    end
    check_value("signed_rescale", -32, model_result(s));
    stim_q.push_back(s);
    // mixed signs against -0.75
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = (l - 8) * 1001;
      s.w[l] = -(3 << (FRAC - 2));
    end
    stim_q.push_back(s);
    // tiny negative products all floor to -1
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = -(2 * l + 1);
      s.w[l] = 3;
    end
    check_value("signed_rescale", -16, model_result(s));
    stim_q.push_back(s);
    // near full scale times 1.0 so the sum wraps
    for (int l = 0; l < NUM_LANES; l++) begin
      s.x[l] = 32'sh7fff_fff0;
      s.w[l] = 1 << FRAC;
    end
    check_value("signed_rescale", -256, model_result(s));
    stim_q.push_back(s);
    run_stream("signed_rescale", 1'b0, 1'b0, stalled);
    end_test("signed_rescale");
  endtask

  task automatic random_stream();
    stim_q.delete();
    repeat (40) stim_q.push_back(random_sample());
    run_stream("random_stream", 1'b0, 1'b0, stalled);
    end_test("random_stream");
  endtask

  task automatic backpressure();
    stim_q.delete();
    repeat (30) stim_q.push_back(random_sample());
    run_stream("backpressure", 1'b1, 1'b1, stalled);
    assert (stalled) else begin
      $display("backpressure: o_ready never fell while i_ready was low");
      errs++;
    end
    end_test("backpressure");
  endtask

  initial begin
    rng_state    = 32'd48;
    errs         = 0;
    tests_passed = 0;
    tests_failed = 0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_sample     = '0;
    i_ready      = 1'b0;
    reset_state();
    single_known();
    signed_rescale();
    random_stream();
    backpressure();
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
common/dot_pkg.sv
pe8/lane_multiplier.sv
pe8/partial_sum_tree.sv
hdl/result_combiner.sv
hdl/dot_layer_top.sv
tests/dot_layer_sva.sv
tests/tb_dot_layer.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_dot_layer -f all.f
	./obj_dir/Vtb_dot_layer | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
